// ==== src/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // Host sample and DAC channel widths
    typedef logic [15:0] sample_t;
    typedef logic [7:0]  color_t;

    // Pixel position inside the visible area
    typedef logic [9:0]  coord_t;

    // Up to 4096 tiles
    typedef logic [11:0] tile_addr_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // Everything the pipeline needs to know about one pixel slot
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   hsync_n;
        logic   vsync_n;
    } pixel_info_t;

    // Blanked pixel with both syncs released
    localparam pixel_info_t PIXEL_IDLE = '{
        x:       '0,
        y:       '0,
        active:  1'b0,
        hsync_n: 1'b1,
        vsync_n: 1'b1
    };

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } timing_state_t;

endpackage

`default_nettype wire

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACT   = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC  = 96,
    parameter int H_BACK  = 48,
    parameter int V_ACT   = 480,
    parameter int V_FRONT = 10,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 33
) (
    input  wire                  i_clk_25M,
    input  wire                  i_rst,
    input  wire                  i_enable,
    output vga_pkg::pixel_info_t o_pixel
);
    import vga_pkg::*;

    localparam int H_TOTAL = H_SYNC + H_BACK + H_ACT + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_ACT + V_FRONT;
    localparam int HW = $clog2(H_TOTAL + 1);
    localparam int VW = $clog2(V_TOTAL + 1);

    // Line order is sync, back porch, active, front porch
    localparam logic [HW-1:0] H_LAST     = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_SYNC_END = HW'(H_SYNC);
    localparam logic [HW-1:0] H_ACT_BEG  = HW'(H_SYNC + H_BACK);
    localparam logic [HW-1:0] H_ACT_END  = HW'(H_SYNC + H_BACK + H_ACT);
    localparam logic [VW-1:0] V_LAST     = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_SYNC_END = VW'(V_SYNC);
    localparam logic [VW-1:0] V_ACT_BEG  = VW'(V_SYNC + V_BACK);
    localparam logic [VW-1:0] V_ACT_END  = VW'(V_SYNC + V_BACK + V_ACT);

    timing_state_t   state_r, state_w;
    logic [HW-1:0]   h_cnt_r, h_cnt_w;
    logic [VW-1:0]   v_cnt_r, v_cnt_w;
    logic            run;
    logic            h_act;
    logic            v_act;

    always_comb begin
        state_w = state_r;
        h_cnt_w = h_cnt_r;
        v_cnt_w = v_cnt_r;
        case (state_r)
            ST_IDLE: begin
                h_cnt_w = '0;
                v_cnt_w = '0;
                if (i_enable) begin
                    state_w = ST_RUN;
                end
            end
            ST_RUN: begin
                if (!i_enable) begin
                    state_w = ST_IDLE;
                    h_cnt_w = '0;
                    v_cnt_w = '0;
                end else if (h_cnt_r == H_LAST) begin
                    h_cnt_w = '0;
                    // Frame wraps together with the last line
                    v_cnt_w = (v_cnt_r == V_LAST) ? '0 : v_cnt_r + VW'(1);
                end else begin
                    h_cnt_w = h_cnt_r + HW'(1);
                end
            end
            default: state_w = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            state_r <= ST_IDLE;
            h_cnt_r <= '0;
            v_cnt_r <= '0;
        end else begin
            state_r <= state_w;
            h_cnt_r <= h_cnt_w;
            v_cnt_r <= v_cnt_w;
        end
    end

    // Decode straight from the registered counters
    assign run   = (state_r == ST_RUN);
    assign h_act = (h_cnt_r >= H_ACT_BEG) && (h_cnt_r < H_ACT_END);
    assign v_act = (v_cnt_r >= V_ACT_BEG) && (v_cnt_r < V_ACT_END);

    always_comb begin
        o_pixel         = PIXEL_IDLE;
        o_pixel.hsync_n = !(run && (h_cnt_r < H_SYNC_END));
        o_pixel.vsync_n = !(run && (v_cnt_r < V_SYNC_END));
        o_pixel.active  = run && h_act && v_act;
        if (o_pixel.active) begin
            o_pixel.x = coord_t'(h_cnt_r - H_ACT_BEG);
            o_pixel.y = coord_t'(v_cnt_r - V_ACT_BEG);
        end
    end

endmodule

`default_nettype wire

// ==== src/sample_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
    parameter int H_ACT      = 640,
    parameter int V_ACT      = 480,
    parameter int TILE_SHIFT = 4
) (
    input  wire                  i_clk_25M,
    input  wire                  i_rst,
    input  wire                  i_wr_en,
    input  vga_pkg::tile_addr_t  i_wr_addr,
    input  vga_pkg::sample_t     i_wr_data,
    input  vga_pkg::pixel_info_t i_pixel,
    output vga_pkg::sample_t     o_sample,
    output vga_pkg::pixel_info_t o_pixel
);
    import vga_pkg::*;

    localparam int TILES_X = H_ACT >> TILE_SHIFT;
    localparam int TILES_Y = V_ACT >> TILE_SHIFT;
    localparam int DEPTH   = TILES_X * TILES_Y;
    localparam int AW      = $clog2(DEPTH);

    sample_t         mem [DEPTH];
    logic [AW-1:0]   rd_idx;
    logic [AW-1:0]   wr_idx;
    logic            wr_ok;

    // Row of tiles times tiles per row, plus tile column
    assign rd_idx = AW'((i_pixel.y >> TILE_SHIFT) * TILES_X + (i_pixel.x >> TILE_SHIFT));

    // Host addresses past the last tile are dropped
    assign wr_ok  = i_wr_en && (i_wr_addr < tile_addr_t'(DEPTH));
    assign wr_idx = i_wr_addr[AW-1:0];

    always_ff @(posedge i_clk_25M) begin
        if (wr_ok) begin
            mem[wr_idx] <= i_wr_data;
        end
        o_sample <= mem[rd_idx];
    end

    // Keep pixel info in step with the read data
    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            o_pixel <= PIXEL_IDLE;
        end else begin
            o_pixel <= i_pixel;
        end
    end

endmodule

`default_nettype wire

// ==== src/heat_colormap.sv ====
`timescale 1ns/1ps
`default_nettype none

module heat_colormap (
    input  wire                  i_clk_25M,
    input  wire                  i_rst,
    input  vga_pkg::sample_t     i_sample,
    input  vga_pkg::pixel_info_t i_pixel,
    output vga_pkg::rgb_t        o_rgb,
    output vga_pkg::pixel_info_t o_pixel
);
    import vga_pkg::*;

    localparam color_t RAMP_LOW  = 8'd32;
    localparam color_t RAMP_HIGH = 8'd200;

    logic [1:0]   seg;
    logic [13:0]  frac;
    color_t       ramp;
    color_t       up;
    color_t       down;
    rgb_t         rgb_w;

    assign seg  = i_sample[15:14];
    assign frac = i_sample[13:0];

    // 168 * f / 16384 without a divider, at most 167
    assign ramp = color_t'((22'(frac) * 22'd168) >> 14);
    assign up   = RAMP_LOW + ramp;
    assign down = RAMP_HIGH - ramp;

    // Blue, then green, then red, then fading to dark red
    always_comb begin
        rgb_w = '0;
        case (seg)
            2'd0: begin
                rgb_w.b = up;
            end
            2'd1: begin
                rgb_w.g = up;
                rgb_w.b = down;
            end
            2'd2: begin
                rgb_w.r = up;
                rgb_w.g = down;
            end
            default: begin
                rgb_w.r = down;
            end
        endcase
    end

    always_ff @(posedge i_clk_25M) begin
        o_rgb <= rgb_w;
    end

    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            o_pixel <= PIXEL_IDLE;
        end else begin
            o_pixel <= i_pixel;
        end
    end

endmodule

`default_nettype wire

// ==== src/vga_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_output (
    input  wire                  i_clk_25M,
    input  wire                  i_rst,
    input  vga_pkg::rgb_t        i_rgb,
    input  vga_pkg::pixel_info_t i_pixel,
    output vga_pkg::color_t      o_vga_r,
    output vga_pkg::color_t      o_vga_g,
    output vga_pkg::color_t      o_vga_b,
    output logic                 o_vga_hs,
    output logic                 o_vga_vs,
    output logic                 o_vga_blank_n
);
    import vga_pkg::*;

    rgb_t shown;

    // Black anywhere outside the visible window
    assign shown = i_pixel.active ? i_rgb : '0;

    always_ff @(posedge i_clk_25M or posedge i_rst) begin
        if (i_rst) begin
            o_vga_r       <= '0;
            o_vga_g       <= '0;
            o_vga_b       <= '0;
            o_vga_hs      <= 1'b1;
            o_vga_vs      <= 1'b1;
            o_vga_blank_n <= 1'b0;
        end else begin
            o_vga_r       <= shown.r;
            o_vga_g       <= shown.g;
            o_vga_b       <= shown.b;
            o_vga_hs      <= i_pixel.hsync_n;
            o_vga_vs      <= i_pixel.vsync_n;
            o_vga_blank_n <= i_pixel.active;
        end
    end

endmodule

`default_nettype wire

// ==== src/vga_heatmap_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_heatmap_top #(
    parameter int H_ACT      = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_ACT      = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int TILE_SHIFT = 4
) (
    input  wire                 i_clk_25M,
    input  wire                 i_rst,
    input  wire                 i_enable,
    input  wire                 i_wr_en,
    input  vga_pkg::tile_addr_t i_wr_addr,
    input  vga_pkg::sample_t    i_wr_data,
    output vga_pkg::color_t     o_vga_r,
    output vga_pkg::color_t     o_vga_g,
    output vga_pkg::color_t     o_vga_b,
    output logic                o_vga_hs,
    output logic                o_vga_vs,
    output logic                o_vga_blank_n
);
    import vga_pkg::*;

    // One register per stage after the raster counters
    pixel_info_t raster_pixel;
    pixel_info_t buf_pixel;
    pixel_info_t map_pixel;
    sample_t     buf_sample;
    rgb_t        map_rgb;

    vga_timing #(
        .H_ACT   (H_ACT),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACT   (V_ACT),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) i_vga_timing (
        .i_clk_25M (i_clk_25M),
        .i_rst     (i_rst),
        .i_enable  (i_enable),
        .o_pixel   (raster_pixel)
    );

    sample_buffer #(
        .H_ACT      (H_ACT),
        .V_ACT      (V_ACT),
        .TILE_SHIFT (TILE_SHIFT)
    ) i_sample_buffer (
        .i_clk_25M (i_clk_25M),
        .i_rst     (i_rst),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_pixel   (raster_pixel),
        .o_sample  (buf_sample),
        .o_pixel   (buf_pixel)
    );

    heat_colormap i_heat_colormap (
        .i_clk_25M (i_clk_25M),
        .i_rst     (i_rst),
        .i_sample  (buf_sample),
        .i_pixel   (buf_pixel),
        .o_rgb     (map_rgb),
        .o_pixel   (map_pixel)
    );

    vga_output i_vga_output (
        .i_clk_25M     (i_clk_25M),
        .i_rst         (i_rst),
        .i_rgb         (map_rgb),
        .i_pixel       (map_pixel),
        .o_vga_r       (o_vga_r),
        .o_vga_g       (o_vga_g),
        .o_vga_b       (o_vga_b),
        .o_vga_hs      (o_vga_hs),
        .o_vga_vs      (o_vga_vs),
        .o_vga_blank_n (o_vga_blank_n)
    );

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    // Free running, starts low
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_vga_heatmap.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vga_heatmap;
    import vga_pkg::*;

    // 48 clocks per line, 22 lines per frame
    localparam int FRAME     = 48 * 22;
    localparam int TIMEOUT   = 2 * FRAME;
    localparam int NTILES    = 8;
    localparam int SIG_HS    = 0;
    localparam int SIG_VS    = 1;
    localparam int SIG_BLANK = 2;

    logic        clk_25M;
    logic        rst;
    logic        enable;
    logic        wr_en;
    tile_addr_t  wr_addr;
    sample_t     wr_data;
    color_t      vga_r;
    color_t      vga_g;
    color_t      vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;

    sample_t     tiles [NTILES];
    logic [15:0] lfsr;
    int          errors;
    int          err_start;
    int          checks;
    int          tests;
    string       test_name;

    clock_gen #(.PERIOD_NS(40)) i_clock_gen (.o_clk(clk_25M));

    vga_heatmap_top #(
        .H_ACT      (32),
        .H_FRONT    (4),
        .H_SYNC     (8),
        .H_BACK     (4),
        .V_ACT      (16),
        .V_FRONT    (2),
        .V_SYNC     (2),
        .V_BACK     (2),
        .TILE_SHIFT (3)
    ) i_vga_heatmap_top (
        .i_clk_25M     (clk_25M),
        .i_rst         (rst),
        .i_enable      (enable),
        .i_wr_en       (wr_en),
        .i_wr_addr     (wr_addr),
        .i_wr_data     (wr_data),
        .o_vga_r       (vga_r),
        .o_vga_g       (vga_g),
        .o_vga_b       (vga_b),
        .o_vga_hs      (vga_hs),
        .o_vga_vs      (vga_vs),
        .o_vga_blank_n (vga_blank_n)
    );

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // Expected colour straight from the four-segment ramp rule
    function automatic rgb_t ref_color(input sample_t s);
        int   f;
        int   ramp;
        rgb_t c;
        f    = int'(s) % 16384;
        ramp = (168 * f) / 16384;
        c    = '0;
        case (int'(s) / 16384)
            0: c.b = color_t'(32 + ramp);
            1: begin
                c.g = color_t'(32 + ramp);
                c.b = color_t'(200 - ramp);
            end
            2: begin
                c.r = color_t'(32 + ramp);
                c.g = color_t'(200 - ramp);
            end
            default: c.r = color_t'(200 - ramp);
        endcase
        return c;
    endfunction

    function automatic rgb_t dut_rgb();
        return rgb_t'({vga_r, vga_g, vga_b});
    endfunction

    function automatic logic pick(input int which);
        case (which)
            SIG_HS:  return vga_hs;
            SIG_VS:  return vga_vs;
            default: return vga_blank_n;
        endcase
    endfunction

    function automatic string sig_name(input int which);
        case (which)
            SIG_HS:  return "hsync";
            SIG_VS:  return "vsync";
            default: return "blank_n";
        endcase
    endfunction

    function automatic logic outputs_idle();
        return vga_hs === 1'b1 && vga_vs === 1'b1 && vga_blank_n === 1'b0
            && dut_rgb() === rgb_t'(0);
    endfunction

    // Land 1 ns after the edge, where outputs are settled and inputs change
    task automatic step();
        @(posedge clk_25M);
        #1;
    endtask

    task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    // Steps taken until the output reaches the level, -1 on timeout
    task automatic measure_until(input int which, input logic level, output int steps);
        steps = 0;
        while (pick(which) !== level && steps < TIMEOUT) begin
            step();
            steps++;
        end
        if (pick(which) !== level) begin
            errors++;
            $display("Timed out in %s waiting for %s to reach %b",
                     test_name, sig_name(which), level);
            steps = -1;
        end
    endtask

    task automatic wait_edge(input int which, input logic level);
        int unused;
        measure_until(which, !level, unused);
        measure_until(which, level, unused);
    endtask

    task automatic set_enable(input logic value);
        enable = value;
        step();
    endtask

    task automatic next_random(output sample_t value);
        for (int i = 0; i < 16; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[14:0], lfsr[0]};
        end
    endtask

    task automatic write_tiles();
        for (int i = 0; i < NTILES; i++) begin
            wr_en   = 1'b1;
            wr_addr = tile_addr_t'(i);
            wr_data = tiles[i];
            step();
        end
        wr_en = 1'b0;
    endtask

    task automatic check_outputs_idle();
        check_level("hsync", 1'b1, vga_hs);
        check_level("vsync", 1'b1, vga_vs);
        check_level("blank_n", 1'b0, vga_blank_n);
        check_rgb("colour", '0, dut_rgb());
    endtask

    task automatic check_sync_periods();
        int low;
        int high;
        wait_edge(SIG_HS, 1'b0);
        measure_until(SIG_HS, 1'b1, low);
        measure_until(SIG_HS, 1'b0, high);
        check_count("hsync width", 8, low);
        check_count("hsync period", 48, low + high);
        wait_edge(SIG_VS, 1'b0);
        measure_until(SIG_VS, 1'b1, low);
        measure_until(SIG_VS, 1'b0, high);
        check_count("vsync width", 96, low);
        check_count("vsync period", FRAME, low + high);
    endtask

    // x and y come from blank_n runs counted from the vsync fall
    task automatic check_frame();
        int x;
        int y;
        int shown;
        x     = 0;
        y     = 0;
        shown = 0;
        wait_edge(SIG_VS, 1'b0);
        repeat (FRAME) begin
            if (vga_blank_n === 1'b1) begin
                check_rgb($sformatf("pixel %0d,%0d", x, y),
                          ref_color(tiles[(y >> 3) * 4 + (x >> 3)]), dut_rgb());
                x++;
                shown++;
            end else begin
                check_rgb("blanked colour", '0, dut_rgb());
                if (x != 0) begin
                    y++;
                    x = 0;
                end
            end
            step();
        end
        check_count("pixels checked", 512, shown);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("Test %-14s %s", test_name, (errors == err_start) ? "passed" : "failed");
    endtask

    task automatic test_idle();
        start_test("idle");
        repeat (100) begin
            check_outputs_idle();
            step();
        end
        finish_test();
    endtask

    task automatic test_sync_timing();
        int gap;
        int lead;
        start_test("sync_timing");
        set_enable(1'b1);
        check_sync_periods();
        wait_edge(SIG_BLANK, 1'b1);
        repeat (15) begin
            measure_until(SIG_HS, 1'b0, gap);
            measure_until(SIG_BLANK, 1'b1, lead);
            check_count("blank to next hsync", 36, gap);
            check_count("hsync to blank", 12, lead);
        end
        finish_test();
    endtask

    task automatic test_active_window();
        int width;
        int count;
        start_test("active_window");
        wait_edge(SIG_BLANK, 1'b1);
        measure_until(SIG_BLANK, 1'b0, width);
        check_count("active line width", 32, width);
        wait_edge(SIG_VS, 1'b0);
        count = 0;
        repeat (FRAME) begin
            if (vga_blank_n === 1'b1) begin
                count++;
            end else begin
                check_rgb("blanked colour", '0, dut_rgb());
            end
            step();
        end
        check_count("active pixels per frame", 512, count);
        finish_test();
    endtask

    task automatic test_segments();
        start_test("segments");
        set_enable(1'b0);
        tiles = '{16'd0, 16'd16383, 16'd16384, 16'd32767,
                  16'd32768, 16'd49151, 16'd49152, 16'd65535};
        write_tiles();
        set_enable(1'b1);
        // Skip the first frame, check the second
        wait_edge(SIG_VS, 1'b0);
        check_frame();
        finish_test();
    endtask

    task automatic test_random();
        start_test("random");
        set_enable(1'b0);
        for (int i = 0; i < NTILES; i++) begin
            next_random(tiles[i]);
        end
        write_tiles();
        set_enable(1'b1);
        check_frame();
        finish_test();
    endtask

    task automatic test_enable_drop();
        int waited;
        start_test("enable_drop");
        wait_edge(SIG_BLANK, 1'b1);
        repeat (16) step();
        enable = 1'b0;
        waited = 0;
        while (!outputs_idle() && waited < 4) begin
            step();
            waited++;
        end
        if (!outputs_idle()) begin
            errors++;
            $display("Outputs in %s were not idle 4 cycles after enable dropped", test_name);
        end
        repeat (100) begin
            check_outputs_idle();
            step();
        end
        set_enable(1'b1);
        check_sync_periods();
        finish_test();
    endtask

    initial begin
        rst     = 1'b1;
        enable  = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        lfsr    = 16'd10;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        repeat (8) @(posedge clk_25M);
        #1;
        rst = 1'b0;

        test_idle();
        test_sync_timing();
        test_active_window();
        test_segments();
        test_random();
        test_enable_drop();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/vga_pkg.sv
src/vga_timing.sv
src/sample_buffer.sv
src/heat_colormap.sv
src/vga_output.sv
src/vga_heatmap_top.sv
test/clock_gen.sv
test/tb_vga_heatmap.sv

// ==== Makefile ====
TOP := tb_vga_heatmap

all: run

obj_dir/V$(TOP): all.f src/*.sv test/*.sv
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
